// ==== all.f ====
hdl/wavegen_pkg.sv
hdl/wavegen_ctrl.sv
hdl/phase_step.sv
hdl/wave_rom.sv
hdl/amp_scale.sv
hdl/wavegen_top.sv
testbench/wavegen_tb.sv

// ==== hdl/amp_scale.sv ====
// Amplitude scaling and the output sample register.
// The table word is multiplied by a fixed point gain and the result is
// registered together with its valid flag.
module amp_scale (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 load_i,
	input  wavegen_pkg::amp_t    amp_i,
	input  wavegen_pkg::sample_t data_i,
	input  logic                 step_i,
	output wavegen_pkg::sample_t sample_o,
	output logic                 sample_valid_o
);

	// Full product width of two samples.
	localparam int PROD_WIDTH = 2 * wavegen_pkg::DATA_WIDTH;

	wavegen_pkg::sample_t         amp_q;
	logic signed [PROD_WIDTH-1:0] product;
	logic                         step_d1;
	logic                         valid_q;
	wavegen_pkg::sample_t         sample_q;

	// The gain is kept with its integer part on top of the fraction bits.
	// An integer amplitude therefore lands as a whole number in fixed point.
	always_ff @(posedge clk) begin
		if (rst) begin
			amp_q <= {wavegen_pkg::AMP_RESET, {wavegen_pkg::FRAC_BITS{1'b0}}};
		end else if (load_i) begin
			amp_q <= {amp_i, {wavegen_pkg::FRAC_BITS{1'b0}}};
		end
	end

	// Signed by signed gives a signed product.
	assign product = data_i * amp_q;

	// The step reaches here two edges late, matching the address and ROM stages.
	// The first delay lines up with the ROM word, the second with the sample.
	always_ff @(posedge clk) begin
		if (rst) begin
			step_d1 <= 1'b0;
			valid_q <= 1'b0;
		end else begin
			step_d1 <= step_i;
			valid_q <= step_d1;
		end
	end

	// Dropping the fraction bits undoes the fixed point scale.
	// The upper bits are cut off at the sample width.
	always_ff @(posedge clk) begin
		if (step_d1) begin
			sample_q <= product[wavegen_pkg::FRAC_BITS +: wavegen_pkg::DATA_WIDTH];
		end
	end

	assign sample_o       = sample_q;
	assign sample_valid_o = valid_q;

	// Nothing left in the pipe may come out right after reset.
	valid_after_rst: assert property (@(posedge clk) rst |=> !sample_valid_o)
		else $error("sample valid high right after reset");

endmodule

// ==== hdl/phase_step.sv ====
// Table address register.
// It clears to zero, holds, or advances by one on each step.
module phase_step #(
	parameter int ADDR_WIDTH = 4
) (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  clear_i,
	input  logic                  step_i,
	output logic [ADDR_WIDTH-1:0] addr_o
);

	logic [ADDR_WIDTH-1:0] addr_q;
	logic [ADDR_WIDTH-1:0] addr_next;

	// The sum drops its carry, so the last entry wraps back to entry 0.
	assign addr_next = addr_q + ADDR_WIDTH'(1);

	// Clear has priority over step.
	// The controller never raises both, but the register stays safe if it did.
	always_ff @(posedge clk) begin
		if (rst || clear_i) begin
			addr_q <= '0;
		end else if (step_i) begin
			addr_q <= addr_next;
		end
	end

	// The current address goes to the ROM in the same cycle as the step.
	assign addr_o = addr_q;

	// With neither clear nor step, the address must not move on the next edge.
	addr_hold: assert property (@(posedge clk) disable iff (rst)
		(!clear_i && !step_i) |=> $stable(addr_o))
		else $error("address moved without clear or step");

endmodule

// ==== hdl/wave_rom.hex ====
0000
0310
05A8
0764
0800
0764
05A8
0310
0000
FCF0
FA58
F89C
F800
F89C
FA58
FCF0
0800
0764
05A8
0310
0000
FCF0
FA58
F89C
F800
F89C
FA58
FCF0
0000
0310
05A8
0764
0000
0200
0400
0600
0800
0600
0400
0200
0000
FE00
FC00
FA00
F800
FA00
FC00
FE00
0800
0800
0800
0800
0800
0800
0800
0800
F800
F800
F800
F800
F800
F800
F800
F800

// ==== hdl/wave_rom.sv ====
// Combined waveform table.
// Each shape owns one block of 2**ADDR_WIDTH words, sine first and square last.
// The shape select sits in the upper address bits.
module wave_rom #(
	parameter int ADDR_WIDTH = 4
) (
	input  logic                         clk,
	input  logic                         rst,
	input  logic                         load_i,
	input  wavegen_pkg::shape_t          shape_i,
	input  logic [ADDR_WIDTH-1:0]        addr_i,
	output wavegen_pkg::sample_t         data_o
);

	// Four shapes share the table.
	localparam int ROM_DEPTH = 4 * (2 ** ADDR_WIDTH);

	wavegen_pkg::shape_t  shape_q;
	wavegen_pkg::sample_t table_mem [ROM_DEPTH];
	wavegen_pkg::sample_t data_q;
	logic [ADDR_WIDTH+1:0] rom_addr;

	// The table holds sixteen words per shape at the default address width.
	initial begin
		$readmemh("hdl/wave_rom.hex", table_mem);
	end

	// The select is taken while the controller is in Configure.
	// It takes effect from the next cycle.
	always_ff @(posedge clk) begin
		if (rst) begin
			shape_q <= wavegen_pkg::SHAPE_SINE;
		end else if (load_i) begin
			shape_q <= shape_i;
		end
	end

	// Shape picks the block and the phase address picks the word inside it.
	assign rom_addr = {shape_q, addr_i};

	// Registered read every cycle.
	// The word for a step shows up one cycle after the step.
	always_ff @(posedge clk) begin
		data_q <= table_mem[rom_addr];
	end

	assign data_o = data_q;

endmodule

// ==== hdl/wavegen_ctrl.sv ====
// Controller for the waveform generator.
// It runs the Idle, Configure and Generate sequence and keeps the credit count.
// A step is issued only in Generate and only while a credit is left.
module wavegen_ctrl #(
	parameter int CREDITS = 4
) (
	input  logic clk,
	input  logic rst,
	input  logic conf_i,
	input  logic stop_i,
	input  logic credit_i,
	output logic clear_o,
	output logic load_o,
	output logic step_o
);

	// Wide enough to hold the full credit count.
	localparam int CNT_WIDTH = $clog2(CREDITS + 1);

	wavegen_pkg::ctrl_state_t state_q;
	wavegen_pkg::ctrl_state_t state_d;
	logic [CNT_WIDTH-1:0]     credit_cnt_q;

	// Next state.
	// A configure request always wins, then stop decides between Idle and Generate.
	always_comb begin
		state_d = state_q;
		case (state_q)
			wavegen_pkg::ST_IDLE: begin
				if (conf_i) begin
					state_d = wavegen_pkg::ST_CONF;
				end else if (!stop_i) begin
					state_d = wavegen_pkg::ST_GEN;
				end
			end
			wavegen_pkg::ST_CONF: begin
				if (conf_i) begin
					state_d = wavegen_pkg::ST_CONF;
				end else if (stop_i) begin
					state_d = wavegen_pkg::ST_IDLE;
				end else begin
					state_d = wavegen_pkg::ST_GEN;
				end
			end
			wavegen_pkg::ST_GEN: begin
				if (conf_i) begin
					state_d = wavegen_pkg::ST_CONF;
				end else if (stop_i) begin
					state_d = wavegen_pkg::ST_IDLE;
				end
			end
			default: state_d = wavegen_pkg::ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= wavegen_pkg::ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// The address is held at zero outside Generate, so the next run starts at entry 0.
	assign clear_o = (state_q == wavegen_pkg::ST_IDLE) || (state_q == wavegen_pkg::ST_CONF);
	assign load_o  = (state_q == wavegen_pkg::ST_CONF);
	assign step_o  = (state_q == wavegen_pkg::ST_GEN) && (credit_cnt_q != '0);

	// Each step spends a credit and each returned credit adds one.
	// Both in the same cycle leave the count where it is.
	always_ff @(posedge clk) begin
		if (rst) begin
			credit_cnt_q <= CNT_WIDTH'(CREDITS);
		end else if (step_o && !credit_i) begin
			credit_cnt_q <= credit_cnt_q - 1'b1;
		end else if (credit_i && !step_o) begin
			credit_cnt_q <= credit_cnt_q + 1'b1;
		end
	end

	// The consumer must never return more credits than it was given.
	credit_limit: assert property (@(posedge clk) disable iff (rst)
		credit_cnt_q <= CREDITS)
		else $error("credit count %0d above %0d", credit_cnt_q, CREDITS);

	// The address register would see clear and step at once otherwise.
	step_clear_excl: assert property (@(posedge clk) disable iff (rst) !(step_o && clear_o))
		else $error("step and clear high together");

endmodule

// ==== hdl/wavegen_pkg.sv ====
// Shared widths, types and constants for the waveform generator.
// Every design file refers to these by scoped name.
package wavegen_pkg;

	// Width of a table word and of an output sample.
	localparam int DATA_WIDTH = 16;

	// Integer bits of the signed amplitude.
	localparam int INT_BITS = 4;

	// The amplitude sits above this many fraction bits in the fixed point register.
	localparam int FRAC_BITS = DATA_WIDTH - INT_BITS;

	// A signed table value or a scaled output sample.
	typedef logic signed [DATA_WIDTH-1:0] sample_t;

	// The signed amplitude as it arrives from outside.
	typedef logic signed [INT_BITS-1:0] amp_t;

	// Waveform select.
	// The encoding is 0 sine, 1 cosine, 2 triangle and 3 square.
	typedef logic [1:0] shape_t;

	// The select value that the ROM starts from after reset.
	localparam shape_t SHAPE_SINE = 2'd0;

	// Controller states.
	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_CONF = 2'd1,
		ST_GEN  = 2'd2
	} ctrl_state_t;

	// The amplitude after reset is an integer gain of one.
	localparam amp_t AMP_RESET = 4'sd1;

endpackage

// ==== hdl/wavegen_top.sv ====
// Waveform generator top level.
// The controller drives the address register, the table and the scaler.
// Samples leave under credit flow control with a fixed two cycle latency.
module wavegen_top #(
	parameter int ADDR_WIDTH = 4,
	parameter int CREDITS    = 4
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 conf_i,
	input  logic                 stop_i,
	input  wavegen_pkg::shape_t  shape_i,
	input  wavegen_pkg::amp_t    amp_i,
	input  logic                 credit_i,
	output wavegen_pkg::sample_t sample_o,
	output logic                 sample_valid_o
);

	logic                  clear;
	logic                  load;
	logic                  step;
	logic [ADDR_WIDTH-1:0] addr;
	wavegen_pkg::sample_t  rom_data;

	wavegen_ctrl #(
		.CREDITS(CREDITS)
	) u_ctrl (
		.clk     (clk),
		.rst     (rst),
		.conf_i  (conf_i),
		.stop_i  (stop_i),
		.credit_i(credit_i),
		.clear_o (clear),
		.load_o  (load),
		.step_o  (step)
	);

	phase_step #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) u_phase (
		.clk    (clk),
		.rst    (rst),
		.clear_i(clear),
		.step_i (step),
		.addr_o (addr)
	);

	// Shape and amplitude are both taken in Configure.
	wave_rom #(
		.ADDR_WIDTH(ADDR_WIDTH)
	) u_rom (
		.clk    (clk),
		.rst    (rst),
		.load_i (load),
		.shape_i(shape_i),
		.addr_i (addr),
		.data_o (rom_data)
	);

	amp_scale u_scale (
		.clk           (clk),
		.rst           (rst),
		.load_i        (load),
		.amp_i         (amp_i),
		.data_i        (rom_data),
		.step_i        (step),
		.sample_o      (sample_o),
		.sample_valid_o(sample_valid_o)
	);

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the waveform generator testbench with Verilator and runs it.
# The exit status is zero only when the run reports a clean finish.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module wavegen_tb \
	-f all.f -o wavegen_sim; then
	echo "Verilator build failed"
	exit 1
fi

if ! output=$(./obj_dir/wavegen_sim); then
	echo "$output"
	echo "Simulation exited with an error status"
	exit 1
fi

echo "$output"

if echo "$output" | grep -qx "Done: no errors"; then
	exit 0
fi
exit 1

// ==== testbench/wavegen_golden.txt ====
// Record: shape, amplitude (16-bit two's complement), sample count, then the expected samples.
// All words are hex; a record with a sample count of 0000 ends the list.
// Sine at gain 1, long enough to wrap past entry 15.
0000 0001 0014
0000 0310 05A8 0764
0800 0764 05A8 0310
0000 FCF0 FA58 F89C
F800 F89C FA58 FCF0
0000 0310 05A8 0764
// Cosine at gain 2.
0001 0002 0010
1000 0EC8 0B50 0620
0000 F9E0 F4B0 F138
F000 F138 F4B0 F9E0
0000 0620 0B50 0EC8
// Triangle at gain 3.
0002 0003 0012
0000 0600 0C00 1200
1800 1200 0C00 0600
0000 FA00 F400 EE00
E800 EE00 F400 FA00
0000 0600
// Square at the largest positive gain.
0003 0007 0010
3800 3800 3800 3800
3800 3800 3800 3800
C800 C800 C800 C800
C800 C800 C800 C800
// Sine again at gain -2, so every value is negated.
0000 FFFE 0010
0000 F9E0 F4B0 F138
F000 F138 F4B0 F9E0
0000 0620 0B50 0EC8
1000 0EC8 0B50 0620
// Triangle at the most negative gain.
0002 FFF8 0014
0000 F000 E000 D000
C000 D000 E000 F000
0000 1000 2000 3000
4000 3000 2000 1000
0000 F000 E000 D000
// End of the list.
0000 0000 0000

// ==== testbench/wavegen_tb.sv ====
module wavegen_tb;

	localparam int CREDITS   = 4;
	localparam int MAX_WORDS = 256;

	logic                 clk;
	logic                 rst;
	logic                 conf_i;
	logic                 stop_i;
	wavegen_pkg::shape_t  shape_i;
	wavegen_pkg::amp_t    amp_i;
	logic                 credit_i;
	wavegen_pkg::sample_t sample_o;
	logic                 sample_valid_o;

	// The golden file is held flat with one 16-bit word per entry.
	logic [15:0] golden [MAX_WORDS];
	logic [31:0] lfsr;
	int          error_count;
	int          check_total;
	int          cycle_count;
	int          cycle_limit;

	wavegen_top #(
		.ADDR_WIDTH(4),
		.CREDITS   (CREDITS)
	) DUT (
		.clk           (clk),
		.rst           (rst),
		.conf_i        (conf_i),
		.stop_i        (stop_i),
		.shape_i       (shape_i),
		.amp_i         (amp_i),
		.credit_i      (credit_i),
		.sample_o      (sample_o),
		.sample_valid_o(sample_valid_o)
	);

	// Free running clock with a period of 20.
	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	// The cycle watchdog gets its limit once the golden file has been read.
	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout after %0d cycles, the DUT stopped producing samples.", cycle_count);
			$display("Done: errors found");
			$finish;
		end
	end

	// One step of a 32-bit Galois LFSR that shifts right.
	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		logic [31:0] next;
		next = state >> 1;
		if (state[0]) begin
			next = next ^ 32'h80200003;
		end
		return next;
	endfunction

	// Takes count bits from the LFSR, stepping it once per bit.
	task automatic take_bits(input int count, output int value);
		value = 0;
		for (int i = 0; i < count; i++) begin
			value = (value << 1) | int'(lfsr[0]);
			lfsr = lfsr_step(lfsr);
		end
	endtask

	// Compares one output sample against its golden word.
	task automatic check_sample(input string name, input wavegen_pkg::sample_t got,
			input wavegen_pkg::sample_t expected);
		check_total++;
		if (got !== expected) begin
			error_count++;
			$display("Error at %0t: %s got %0d (%h), expected %0d (%h)",
				$time, name, got, got, expected, expected);
		end
	endtask

	// Compares a count of events against the number that should have happened.
	task automatic check_count(input string name, input int got, input int expected);
		check_total++;
		if (got != expected) begin
			error_count++;
			$display("Error at %0t: %s got %0d, expected %0d", $time, name, got, expected);
		end
	endtask

	// Configures one shape and amplitude, runs Generate and compares every sample.
	// Credits come back at random gaps, never ahead of the samples that used them.
	task automatic run_record(input int index, input int base, input int count,
			input wavegen_pkg::shape_t shape, input wavegen_pkg::amp_t amp);
		int received;
		int returned;
		int delay;
		int tail_valid;
		int errors_before;
		errors_before = error_count;
		received      = 0;
		returned      = 0;
		tail_valid    = 0;
		take_bits(2, delay);
		@(negedge clk);
		shape_i = shape;
		amp_i   = amp;
		conf_i  = 1'b1;
		stop_i  = 1'b0;
		@(negedge clk);
		conf_i = 1'b0;
		while (received < count) begin
			@(negedge clk);
			credit_i = 1'b0;
			if (sample_valid_o) begin
				check_sample("sample_o", sample_o,
					wavegen_pkg::sample_t'(golden[base + received]));
				received++;
			end
			// Only the credits beyond the initial grant are returned here.
			if (returned < count - CREDITS && returned < received) begin
				if (delay == 0) begin
					credit_i = 1'b1;
					returned++;
					take_bits(2, delay);
				end else begin
					delay--;
				end
			end
		end
		// With every credit spent, nothing more may come out.
		for (int i = 0; i < 6; i++) begin
			@(negedge clk);
			credit_i = 1'b0;
			if (sample_valid_o) begin
				tail_valid++;
			end
		end
		check_count("sample_valid_o count", received + tail_valid, count);
		// Back to Idle, then hand the consumer's remaining space back to the DUT.
		stop_i = 1'b1;
		@(negedge clk);
		for (int i = 0; i < CREDITS; i++) begin
			credit_i = 1'b1;
			@(negedge clk);
			credit_i = 1'b0;
			@(negedge clk);
		end
		$display("Record %0d: shape %0d amplitude %0d, %0d samples, %0s", index, shape, amp,
			count, (error_count == errors_before) ? "ok" : "failed");
	endtask

	initial begin
		int base;
		int record;
		int total_samples;
		int idle_valid;
		rst         = 1'b1;
		conf_i      = 1'b0;
		stop_i      = 1'b1;
		shape_i     = '0;
		amp_i       = '0;
		credit_i    = 1'b0;
		lfsr        = 32'h9a88;
		error_count = 0;
		check_total = 0;
		cycle_count = 0;
		cycle_limit = 1000;
		idle_valid  = 0;
		$readmemh("testbench/wavegen_golden.txt", golden);

		// Walk the records once to size the watchdog.
		base          = 0;
		record        = 0;
		total_samples = 0;
		while (base + 3 <= MAX_WORDS && !$isunknown(golden[base + 2])
				&& golden[base + 2] != 16'h0000) begin
			total_samples += int'(golden[base + 2]);
			base          += 3 + int'(golden[base + 2]);
			record++;
		end
		cycle_limit = 100 + record * 40 + total_samples * 10;
		if (record == 0) begin
			error_count++;
			$display("The golden file holds no test records.");
		end

		// Hold reset, then stay in Idle for a few cycles with stop held.
		// No sample may be valid in either phase.
		for (int i = 0; i < 5; i++) begin
			@(negedge clk);
			if (sample_valid_o) begin
				idle_valid++;
			end
		end
		rst = 1'b0;
		for (int i = 0; i < 5; i++) begin
			@(negedge clk);
			if (sample_valid_o) begin
				idle_valid++;
			end
		end
		check_count("sample_valid_o in reset and Idle", idle_valid, 0);
		$display("Reset and Idle: %0s", (idle_valid == 0) ? "ok" : "failed");

		// Each record starts with its shape, amplitude and sample count.
		base = 0;
		for (int r = 0; r < record; r++) begin
			run_record(r, base + 3, int'(golden[base + 2]),
				wavegen_pkg::shape_t'(golden[base][1:0]),
				wavegen_pkg::amp_t'(golden[base + 1][3:0]));
			base += 3 + int'(golden[base + 2]);
		end

		$display("%0d records, %0d checks, %0d errors", record, check_total, error_count);
		if (error_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule
